// File: pipe_pkg.sv
package pipe_pkg;

  typedef logic [8:0]  coord_t;
  typedef logic [9:0]  gap_t;
  typedef logic [23:0] rgb_t;
  typedef logic [4:0]  shade_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed colours.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam rgb_t outline_rgb      = {8'd84,  8'd56,  8'd71};
  localparam rgb_t stripe_light_rgb = {8'd141, 8'd229, 8'd72};
  localparam rgb_t stripe_dark_rgb  = {8'd98,  8'd182, 8'd35};

  // green ramp, light at the low end, dark at the high end.
  localparam rgb_t pipe_ramp [1:21] = '{
    {8'd210, 8'd236, 8'd125}, {8'd217, 8'd243, 8'd131}, {8'd223, 8'd248, 8'd135},
    {8'd228, 8'd253, 8'd139}, {8'd223, 8'd248, 8'd135}, {8'd217, 8'd244, 8'd130},
    {8'd209, 8'd236, 8'd125}, {8'd201, 8'd230, 8'd119}, {8'd192, 8'd222, 8'd112},
    {8'd183, 8'd213, 8'd106}, {8'd172, 8'd204, 8'd98},  {8'd162, 8'd195, 8'd90},
    {8'd152, 8'd186, 8'd83},  {8'd141, 8'd176, 8'd75},  {8'd131, 8'd168, 8'd68},
    {8'd121, 8'd160, 8'd60},  {8'd112, 8'd151, 8'd53},  {8'd104, 8'd144, 8'd48},
    {8'd97,  8'd138, 8'd42},  {8'd90,  8'd132, 8'd37},  {8'd85,  8'd128, 8'd34}
  };

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // column shade tables, indexed by distance from the right edge over two.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam rgb_t lip_shade [0:26] = '{
    outline_rgb,
    pipe_ramp[21], pipe_ramp[21], pipe_ramp[21], pipe_ramp[21],
    pipe_ramp[20], pipe_ramp[19], pipe_ramp[18], pipe_ramp[17], pipe_ramp[16],
    pipe_ramp[15], pipe_ramp[14], pipe_ramp[13], pipe_ramp[12], pipe_ramp[11],
    pipe_ramp[10], pipe_ramp[9],  pipe_ramp[8],  pipe_ramp[7],  pipe_ramp[6],
    pipe_ramp[5],  pipe_ramp[4],  pipe_ramp[3],  pipe_ramp[2],  pipe_ramp[1],
    pipe_ramp[1],
    outline_rgb
  };

  // shaft runs dark to light and back; last inner column repeats ramp 11.
  localparam rgb_t body_shade [0:24] = '{
    outline_rgb,
    pipe_ramp[18], pipe_ramp[17], pipe_ramp[16], pipe_ramp[15], pipe_ramp[14],
    pipe_ramp[13], pipe_ramp[12], pipe_ramp[11], pipe_ramp[10], pipe_ramp[9],
    pipe_ramp[8],  pipe_ramp[7],  pipe_ramp[6],  pipe_ramp[5],  pipe_ramp[4],
    pipe_ramp[5],  pipe_ramp[6],  pipe_ramp[7],  pipe_ramp[8],  pipe_ramp[9],
    pipe_ramp[10], pipe_ramp[11], pipe_ramp[11],
    outline_rgb
  };

endpackage

// File: pipe_region.sv
module pipe_region
  import pipe_pkg::*;
#(
  parameter int pipe_width    = 52,
  parameter int head_width    = 20,
  parameter int pipe_retract  = 2,
  parameter int blank_height  = 30,
  parameter int stripe_height = 20
)
(
  input  coord_t h_line,
  input  coord_t v_line,
  input  coord_t position_h,
  input  coord_t position_v,
  input  gap_t   gap_width,
  input  logic   valid,
  output logic   pipe_hit,
  output logic   pipe_edge,
  output rgb_t   pipe_rgb
);

  localparam logic [10:0] pw       = 11'(pipe_width);
  localparam logic [10:0] hw       = 11'(head_width);
  localparam logic [10:0] pr       = 11'(pipe_retract);
  localparam logic [10:0] top_row  = 11'(blank_height + stripe_height);
  localparam int          lip_last = $high(lip_shade);
  localparam int          body_last = $high(body_shade);

  // widened copies so no sum wraps.
  logic [10:0] h;
  logic [10:0] v;
  logic [10:0] ph;
  logic [10:0] pv;
  logic [10:0] g;

  logic lip_cols;
  logic shaft_cols;
  logic low_lip;
  logic up_lip;
  logic low_shaft;
  logic up_shaft;
  logic lip_in;
  logic shaft_in;
  logic lip_bound;
  logic shaft_bound;

  logic [10:0] lip_dist;
  logic [10:0] body_dist;
  shade_idx_t  lip_idx;
  shade_idx_t  body_idx;

  assign h  = {2'b00, h_line};
  assign v  = {2'b00, v_line};
  assign ph = {2'b00, position_h};
  assign pv = {2'b00, position_v};
  assign g  = {1'b0, gap_width};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // coverage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lip_cols   = (h + pw >= ph) && (h <= ph);
  assign shaft_cols = (h + pw >= ph + pr) && (h + pr <= ph);
  assign low_lip    = (v >= pv) && (v <= pv + hw);
  assign up_lip     = (v + g + hw >= pv) && (v + g <= pv);
  assign low_shaft  = (v >= pv + hw);
  assign up_shaft   = (v >= top_row) && (v + g + hw <= pv);

  assign lip_in   = lip_cols && (low_lip || up_lip);
  assign shaft_in = shaft_cols && (low_shaft || up_shaft);

  // outline on the lip box edges and on the shaft sides.
  assign lip_bound = (h + pw == ph) || (h == ph) ||
                     (v == pv) || (v == pv + hw) ||
                     (v + g == pv) || (v + g + hw == pv);
  assign shaft_bound = (h + pw == ph + pr) || (h + pr == ph);

  assign pipe_hit  = valid && (lip_in || shaft_in);
  assign pipe_edge = valid && (lip_in ? lip_bound : (shaft_in && shaft_bound));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shade lookup.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lip_dist  = ph - h;
  assign body_dist = ph - (h + pr);

  // clamp to the last entry when the pixel lies off the table.
  always_comb
  begin
    if (lip_dist[10:1] > 10'(lip_last))
      lip_idx = shade_idx_t'(lip_last);
    else
      lip_idx = lip_dist[5:1];
    if (body_dist[10:1] > 10'(body_last))
      body_idx = shade_idx_t'(body_last);
    else
      body_idx = body_dist[5:1];
  end

  assign pipe_rgb = lip_in ? lip_shade[lip_idx] : body_shade[body_idx];

  // covered pixels never need the clamp.
  always_comb
  begin
    assert final (!pipe_hit ||
                  (lip_in ? (lip_dist[10:1] <= 10'(lip_last))
                          : (body_dist[10:1] <= 10'(body_last))))
      else $error("pipe_region: covered pixel indexes past its shade table");
  end

endmodule

// File: ground_stripe.sv
module ground_stripe
  import pipe_pkg::*;
#(
  parameter int blank_height  = 30,
  parameter int stripe_height = 20,
  parameter int stripe_offset = 30
)
(
  input  coord_t h_line,
  input  coord_t v_line,
  input  coord_t position_stripe,
  output logic   band_hit,
  output logic   band_edge,
  output rgb_t   band_rgb
);

  localparam logic [10:0] band_top    = 11'(blank_height);
  localparam logic [10:0] band_bottom = 11'(blank_height + stripe_height);

  logic [10:0] v;
  coord_t      phase;

  assign v = {2'b00, v_line};

  assign band_hit  = (v >= band_top) && (v <= band_bottom);
  assign band_edge = (v == band_top) || (v == band_bottom);

  // diagonal stripes, eight pixels per half period, moving with position.
  assign phase = h_line + coord_t'(stripe_offset) - v_line - position_stripe;

  assign band_rgb = phase[3] ? stripe_light_rgb : stripe_dark_rgb;

endmodule

// File: pixel_select.sv
module pixel_select
  import pipe_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic pipe_1_hit,
  input  logic pipe_1_edge,
  input  logic pipe_2_hit,
  input  logic pipe_2_edge,
  input  logic band_hit,
  input  logic band_edge,
  input  rgb_t pipe_1_rgb,
  input  rgb_t pipe_2_rgb,
  input  rgb_t band_rgb,
  output logic valid_out,
  output rgb_t color_out
);

  logic any_hit;
  logic any_edge;
  rgb_t next_rgb;

  assign any_hit  = pipe_1_hit || pipe_2_hit || band_hit;
  assign any_edge = (pipe_1_hit && pipe_1_edge) ||
                    (pipe_2_hit && pipe_2_edge) ||
                    (band_hit && band_edge);

  // ground band sits in front of both pipes, pipe 1 in front of pipe 2.
  always_comb
  begin
    if (!any_hit)
      next_rgb = '0;
    else if (any_edge)
      next_rgb = outline_rgb;
    else if (band_hit)
      next_rgb = band_rgb;
    else if (pipe_1_hit)
      next_rgb = pipe_1_rgb;
    else
      next_rgb = pipe_2_rgb;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_out <= 1'b0;
      color_out <= '0;
    end
    else
    begin
      valid_out <= any_hit;
      color_out <= next_rgb;
    end
  end

  // output is black exactly for blank pixels.
  a_black_iff_blank: assert property (
    @(posedge clk) disable iff (!rst_n) valid_out == (color_out != '0)
  ) else $error("pixel_select: colour and valid disagree");

endmodule

// File: pipe_render.sv
module pipe_render
  import pipe_pkg::*;
#(
  parameter int pipe_width    = 52,
  parameter int head_width    = 20,
  parameter int pipe_retract  = 2,
  parameter int blank_height  = 30,
  parameter int stripe_height = 20,
  parameter int stripe_offset = 30
)
(
  input  logic   clk,
  input  logic   rst_n,
  input  coord_t h_line,
  input  coord_t v_line,
  input  coord_t position_1_h,
  input  coord_t position_1_v,
  input  coord_t position_2_h,
  input  coord_t position_2_v,
  input  logic   valid_1,
  input  logic   valid_2,
  input  coord_t position_stripe,
  input  gap_t   gap_width,
  output logic   valid_out,
  output rgb_t   color_out
);

  logic pipe_1_hit;
  logic pipe_1_edge;
  rgb_t pipe_1_rgb;
  logic pipe_2_hit;
  logic pipe_2_edge;
  rgb_t pipe_2_rgb;
  logic band_hit;
  logic band_edge;
  rgb_t band_rgb;

  pipe_region #(
    .pipe_width    (pipe_width),
    .head_width    (head_width),
    .pipe_retract  (pipe_retract),
    .blank_height  (blank_height),
    .stripe_height (stripe_height)
  ) u_pipe_1 (
    .h_line     (h_line),
    .v_line     (v_line),
    .position_h (position_1_h),
    .position_v (position_1_v),
    .gap_width  (gap_width),
    .valid      (valid_1),
    .pipe_hit   (pipe_1_hit),
    .pipe_edge  (pipe_1_edge),
    .pipe_rgb   (pipe_1_rgb)
  );

  pipe_region #(
    .pipe_width    (pipe_width),
    .head_width    (head_width),
    .pipe_retract  (pipe_retract),
    .blank_height  (blank_height),
    .stripe_height (stripe_height)
  ) u_pipe_2 (
    .h_line     (h_line),
    .v_line     (v_line),
    .position_h (position_2_h),
    .position_v (position_2_v),
    .gap_width  (gap_width),
    .valid      (valid_2),
    .pipe_hit   (pipe_2_hit),
    .pipe_edge  (pipe_2_edge),
    .pipe_rgb   (pipe_2_rgb)
  );

  ground_stripe #(
    .blank_height  (blank_height),
    .stripe_height (stripe_height),
    .stripe_offset (stripe_offset)
  ) u_ground (
    .h_line          (h_line),
    .v_line          (v_line),
    .position_stripe (position_stripe),
    .band_hit        (band_hit),
    .band_edge       (band_edge),
    .band_rgb        (band_rgb)
  );

  pixel_select u_select (
    .clk         (clk),
    .rst_n       (rst_n),
    .pipe_1_hit  (pipe_1_hit),
    .pipe_1_edge (pipe_1_edge),
    .pipe_2_hit  (pipe_2_hit),
    .pipe_2_edge (pipe_2_edge),
    .band_hit    (band_hit),
    .band_edge   (band_edge),
    .pipe_1_rgb  (pipe_1_rgb),
    .pipe_2_rgb  (pipe_2_rgb),
    .band_rgb    (band_rgb),
    .valid_out   (valid_out),
    .color_out   (color_out)
  );

endmodule

// File: pipe_checker.sv
module pipe_checker
  import pipe_pkg::*;
(
  input logic clk,
  input logic valid_out,
  input rgb_t color_out,
  input logic check_en,
  input logic exp_valid,
  input rgb_t exp_rgb
);

  timeunit 1ns;
  timeprecision 1ps;

  string test_name = "none";
  int    test_checks = 0;
  int    test_errors = 0;
  int    total_checks = 0;
  int    total_errors = 0;
  int    tests_run = 0;

  // expectation for the pixel the DUT registers on this edge.
  logic pend_en = 1'b0;
  logic pend_valid = 1'b0;
  rgb_t pend_rgb = '0;

  always @(posedge clk)
  begin
    pend_en    <= check_en;
    pend_valid <= exp_valid;
    pend_rgb   <= exp_rgb;
  end

  // outputs settle well before the falling edge.
  always @(negedge clk)
  begin
    if (pend_en)
    begin
      test_checks++;
      if (valid_out !== pend_valid || color_out !== pend_rgb)
      begin
        test_errors++;
        $display("ERR %s: expected valid=%0b rgb=%06h, actual valid=%0b rgb=%06h",
                 test_name, pend_valid, pend_rgb, valid_out, color_out);
      end
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    tests_run++;
  endtask

  task automatic print_counts();
    $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
  endtask

endmodule

// File: tb_pipe_render.sv
module tb_pipe_render
  import pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic   clk = 1'b0;
  logic   rst_n;
  coord_t h_line, v_line, position_1_h, position_1_v, position_2_h, position_2_v;
  coord_t position_stripe;
  logic   valid_1, valid_2;
  gap_t   gap_width;
  logic   valid_out;
  rgb_t   color_out;
  logic   check_en, exp_valid;
  rgb_t   exp_rgb;

  // scene held between pixels.
  int p1h, p1v, p2h, p2v, gap, ps;
  bit en1, en2;

  always #50 clk = ~clk;

  pipe_render dut (
    .clk(clk), .rst_n(rst_n), .h_line(h_line), .v_line(v_line),
    .position_1_h(position_1_h), .position_1_v(position_1_v),
    .position_2_h(position_2_h), .position_2_v(position_2_v),
    .valid_1(valid_1), .valid_2(valid_2), .position_stripe(position_stripe),
    .gap_width(gap_width), .valid_out(valid_out), .color_out(color_out)
  );

  pipe_checker u_check (
    .clk(clk), .valid_out(valid_out), .color_out(color_out),
    .check_en(check_en), .exp_valid(exp_valid), .exp_rgb(exp_rgb)
  );

  // one pipe against the geometry rules, widths 52/20/2, band top row 50.
  function automatic void pipe_eval(input int h, input int v, input int ph, input int pv,
                                    input bit en, output bit hit, output bit edg,
                                    output rgb_t rgb);
    bit lip;
    bit shaft;
    int idx;
    lip = (h >= ph - 52 && h <= ph) &&
          ((v >= pv && v <= pv + 20) || (v >= pv - gap - 20 && v <= pv - gap));
    shaft = (h >= ph - 50 && h <= ph - 2) &&
            (v >= pv + 20 || (v >= 50 && v <= pv - gap - 20));
    hit = en && (lip || shaft);
    if (lip)
    begin
      edg = (h == ph - 52 || h == ph || v == pv || v == pv + 20 ||
             v == pv - gap || v == pv - gap - 20);
      idx = (ph - h) / 2;
      rgb = lip_shade[idx > 26 ? 26 : idx];
    end
    else
    begin
      edg = shaft && (h == ph - 50 || h == ph - 2);
      idx = (ph - 2 - h) / 2;
      rgb = body_shade[idx > 24 ? 24 : (idx < 0 ? 0 : idx)];
    end
    edg = edg && hit;
  endfunction

  function automatic logic [24:0] model(input int h, input int v);
    bit h1, e1, h2, e2, bh, be;
    rgb_t c1, c2, bc;
    pipe_eval(h, v, p1h, p1v, en1, h1, e1, c1);
    pipe_eval(h, v, p2h, p2v, en2, h2, e2, c2);
    bh = (v >= 30 && v <= 50);
    be = (v == 30 || v == 50);
    bc = (((h + 30 - v - ps) & 511) & 8) != 0 ? stripe_light_rgb : stripe_dark_rgb;
    if (!(h1 || h2 || bh))
      return '0;
    else if (e1 || e2 || (bh && be))
      return {1'b1, outline_rgb};
    else if (bh)
      return {1'b1, bc};
    else if (h1)
      return {1'b1, c1};
    else
      return {1'b1, c2};
  endfunction

  task automatic drive_expect(input int h, input int v, input bit ev, input rgb_t erg);
    @(posedge clk);
    #5;
    h_line = coord_t'(h);
    v_line = coord_t'(v);
    position_1_h = coord_t'(p1h);
    position_1_v = coord_t'(p1v);
    position_2_h = coord_t'(p2h);
    position_2_v = coord_t'(p2v);
    valid_1 = en1;
    valid_2 = en2;
    position_stripe = coord_t'(ps);
    gap_width = gap_t'(gap);
    check_en = 1'b1;
    exp_valid = ev;
    exp_rgb = erg;
  endtask

  task automatic drive_pixel(input int h, input int v);
    logic [24:0] e;
    e = model(h & 511, v & 511);
    drive_expect(h & 511, v & 511, e[24], e[23:0]);
  endtask

  task automatic finish_test();
    @(posedge clk);
    #5;
    check_en = 1'b0;
    @(negedge clk);
    #1;
    u_check.end_test();
  endtask

  // an overlapping pipe 2 sits a few columns left of pipe 1 so its shades differ.
  task automatic new_scene(input bit overlap);
    p1h = 60 + int'($urandom % 440);
    p1v = 150 + int'($urandom % 250);
    p2h = overlap ? p1h - 4 - int'($urandom % 16) : 60 + int'($urandom % 440);
    p2v = overlap ? p1v : 150 + int'($urandom % 250);
    gap = 40 + int'($urandom % 40);
    ps  = int'($urandom % 512);
  endtask

  initial
  begin
    #2_000_000;
    $display("timeout: simulation ran past its time limit");
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    int i, k, h, v;
    void'($urandom(40));
    {p1h, p1v, p2h, p2v, gap, ps, en1, en2} = '0;
    {h_line, v_line, position_1_h, position_1_v, position_2_h, position_2_v} = '0;
    {valid_1, valid_2, position_stripe, gap_width, check_en, exp_valid, exp_rgb} = '0;
    rst_n = 1'b0;

    // v 0 is blank with both pipes off.
    u_check.start_test("reset");
    for (i = 0; i < 5; i++)
      drive_expect(0, 0, 1'b0, '0);
    rst_n = 1'b1;
    drive_expect(0, 0, 1'b0, '0);
    finish_test();

    u_check.start_test("random_scene");
    en1 = 1;
    en2 = 1;
    for (i = 0; i < 400; i++)
    begin
      if (i % 20 == 0)
        new_scene(0);
      drive_pixel((i % 2 ? p1h : p2h) - int'($urandom % 60), int'($urandom % 512));
    end
    finish_test();

    u_check.start_test("outline");
    en2 = 0;
    for (i = 0; i < 200; i++)
    begin
      new_scene(0);
      k = int'($urandom % 5);
      h = p1h - int'($urandom % 53);
      case (k)
        0: v = p1v + 20 * int'($urandom % 2);
        1: v = p1v - gap - 20 * int'($urandom % 2);
        2: v = 30 + 20 * int'($urandom % 2);
        default:
        begin
          h = (k == 3) ? p1h - 2 - 48 * int'($urandom % 2) : p1h - 52 * int'($urandom % 2);
          v = (k == 3) ? p1v + 21 + int'($urandom % (491 - p1v)) : p1v + int'($urandom % 21);
        end
      endcase
      drive_expect(h, v, 1'b1, outline_rgb);
    end
    finish_test();

    u_check.start_test("ground_band");
    en1 = 0;
    en2 = 0;
    for (i = 0; i < 300; i++)
    begin
      ps = int'($urandom % 512);
      drive_pixel(int'($urandom % 512), int'($urandom % 80));
    end
    finish_test();

    u_check.start_test("priority");
    for (i = 0; i < 300; i++)
    begin
      if (i % 30 == 0)
        new_scene(1);
      en1 = (i < 150);
      en2 = 1;
      drive_pixel(p1h - int'($urandom % 53), 51 + int'($urandom % 461));
    end
    finish_test();

    u_check.start_test("shading");
    en1 = 1;
    en2 = 0;
    for (i = 0; i < 10; i++)
    begin
      new_scene(0);
      p1v = 100 + int'($urandom % 300);
      for (h = p1h - 51; h < p1h; h++)
        drive_expect(h, p1v + 10, 1'b1, lip_shade[(p1h - h) / 2]);
      for (h = p1h - 49; h < p1h - 2; h++)
        drive_expect(h, p1v + 40, 1'b1, body_shade[(p1h - 2 - h) / 2]);
    end
    finish_test();

    u_check.print_counts();
    if (u_check.total_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: src.f
pipe_pkg.sv
pipe_region.sv
ground_stripe.sv
pixel_select.sv
pipe_render.sv
pipe_checker.sv
tb_pipe_render.sv

// File: run.sh
#!/bin/sh
# build and run the pipe renderer testbench with Verilator
verilator --binary --timing --assert -f src.f --top-module tb_pipe_render -o sim_tb \
  && ./obj_dir/sim_tb > run.log 2>&1 \
  ; cat run.log \
  && ! grep -q "Test FAILED" run.log \
  && grep -q "Test OK" run.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
